// ==== hw/alu_cfg.svh ====
// Width and register-count settings shared by the ALU, register file and top level

`ifndef ALU_CFG_SVH
`define ALU_CFG_SVH

// Operand and result width of the datapath
`define ALU_WIDTH 32

// Number of words held in the register file
`define REG_COUNT 8

// Width of a register number, must cover REG_COUNT
`define REG_ADDR_BITS 3

// Reset value of every register and registered output
`define ALU_ZERO {`ALU_WIDTH{1'b0}}

`endif

// ==== hw/aluPkg.sv ====
// Command, slice-select and control types imported by the ALU blocks and the interface

`default_nettype none

package aluPkg;

    // Commands as issued by the requester, same coding as the slice LUT expects
    typedef enum logic [2:0] {
        CMD_ADD  = 3'd0,
        CMD_SUB  = 3'd1,
        CMD_XOR  = 3'd2,
        CMD_SLT  = 3'd3,
        CMD_AND  = 3'd4,
        CMD_NAND = 3'd5,
        CMD_NOR  = 3'd6,
        CMD_OR   = 3'd7
    } aluCmd_t;

    // Which per-bit result a slice drives out
    typedef enum logic [2:0] {
        SEL_SUM     = 3'd0,
        SEL_XOR     = 3'd1,
        SEL_NANDAND = 3'd2,
        SEL_NOROR   = 3'd3,
        SEL_SLT     = 3'd4
    } sliceSel_t;

    // Control word fanned out to every slice
    typedef struct packed {
        sliceSel_t sel;
        logic      invertB;   // Two's complement path for SUB and SLT
        logic      positive;  // AND over NAND, OR over NOR
    } aluCtrl_t;

endpackage

`default_nettype wire

// ==== hw/aluIf.sv ====
// Operand, command, result and flag bundle between the top level and the bit-sliced ALU

`timescale 1ns/1ps
`default_nettype none

`include "alu_cfg.svh"

interface aluIf #(
    parameter int Width = `ALU_WIDTH
) (
    input logic clk  // Sampling clock for checks inside the ALU
);
    import aluPkg::*;

    logic [Width-1:0] operandA;
    logic [Width-1:0] operandB;
    aluCmd_t          command;
    logic [Width-1:0] result;
    logic             carryout;
    logic             zero;
    logic             overflow;

    // Side that issues work
    modport requester(output operandA, operandB, command,
                      input result, carryout, zero, overflow);

    // Side that computes
    modport alu(input clk, operandA, operandB, command,
                output result, carryout, zero, overflow);

endinterface

`default_nettype wire

// ==== hw/aluControl.sv ====
// Command lookup that turns a 3-bit ALU command into the control word of every slice

`timescale 1ns/1ps
`default_nettype none

module aluControl (
    input  aluPkg::aluCmd_t  command,
    output aluPkg::aluCtrl_t ctrl
);
    import aluPkg::*;

    always_comb begin
        ctrl.sel      = SEL_SUM;
        ctrl.invertB  = 1'b0;
        ctrl.positive = 1'b0;
        case (command)
            CMD_ADD:  ctrl.sel = SEL_SUM;
            CMD_SUB: begin
                ctrl.sel     = SEL_SUM;
                ctrl.invertB = 1'b1;  // A + ~B + 1
            end
            CMD_XOR:  ctrl.sel = SEL_XOR;
            CMD_NAND: ctrl.sel = SEL_NANDAND;
            CMD_AND: begin
                ctrl.sel      = SEL_NANDAND;
                ctrl.positive = 1'b1;
            end
            CMD_NOR:  ctrl.sel = SEL_NOROR;
            CMD_OR: begin
                ctrl.sel      = SEL_NOROR;
                ctrl.positive = 1'b1;
            end
            CMD_SLT: begin
                ctrl.sel     = SEL_SLT;
                ctrl.invertB = 1'b1;  // Subtract to compare
            end
            default: begin
                // Unknown code falls back to a plain add
                ctrl.sel      = SEL_SUM;
                ctrl.invertB  = 1'b0;
                ctrl.positive = 1'b0;
            end
        endcase
    end

endmodule

`default_nettype wire

// ==== hw/aluSlice.sv ====
// One-bit ALU slice, chained through its carries to build the full-width ALU

`timescale 1ns/1ps
`default_nettype none

module aluSlice (
    input  logic             a,
    input  logic             b,
    input  logic             carryIn,
    input  aluPkg::aluCtrl_t ctrl,
    output logic             result,
    output logic             carryOut
);
    import aluPkg::*;

    logic trueB;
    logic sumBit;
    logic xorBit;
    logic nandAndBit;
    logic norOrBit;

    // B inverter for the subtract path
    assign trueB = ctrl.invertB ? ~b : b;

    // Full adder
    assign sumBit   = a ^ trueB ^ carryIn;
    assign carryOut = (a & trueB) | (carryIn & (a ^ trueB));

    // Logic ops work on the original B
    assign xorBit     = a ^ b;
    assign nandAndBit = ctrl.positive ? (a & b) : ~(a & b);
    assign norOrBit   = ctrl.positive ? (a | b) : ~(a | b);

    always_comb begin
        case (ctrl.sel)
            SEL_SUM:     result = sumBit;
            SEL_XOR:     result = xorBit;
            SEL_NANDAND: result = nandAndBit;
            SEL_NOROR:   result = norOrBit;
            SEL_SLT:     result = 1'b0;  // Bit 0 gets patched one level up
            default:     result = 1'b0;
        endcase
    end

endmodule

`default_nettype wire

// ==== hw/aluBits.sv ====
// Bit-sliced ALU built from a control lookup and a carry chain of slices, instantiated by the top level

`timescale 1ns/1ps
`default_nettype none

`include "alu_cfg.svh"

module aluBits #(
    parameter int Width = `ALU_WIDTH
) (
    aluIf.alu bus
);
    import aluPkg::*;

    aluCtrl_t         ctrl;
    logic [Width:0]   carry;        // carry[i] feeds slice i
    logic [Width-1:0] sliceResult;
    logic [Width-1:0] finalResult;
    logic             rawOverflow;
    logic             isArith;
    logic             sltSum;
    logic             sltValue;

    aluControl i_aluControl (
        .command(bus.command),
        .ctrl   (ctrl)
    );

    // Bit 0 carry-in completes the two's complement on SUB and SLT
    assign carry[0] = ctrl.invertB;

    for (genvar i = 0; i < Width; i++) begin : g_slice
        aluSlice i_slice (
            .a       (bus.operandA[i]),
            .b       (bus.operandB[i]),
            .carryIn (carry[i]),
            .ctrl    (ctrl),
            .result  (sliceResult[i]),
            .carryOut(carry[i+1])
        );
    end

    // Signed overflow from the carries around the top slice
    assign rawOverflow = carry[Width-1] ^ carry[Width];
    assign isArith     = (ctrl.sel == SEL_SUM) || (ctrl.sel == SEL_SLT);

    // Top slice drives zero on SLT, so rebuild its sum bit here
    assign sltSum   = bus.operandA[Width-1] ^ ~bus.operandB[Width-1] ^ carry[Width-1];
    assign sltValue = sltSum ^ rawOverflow;  // True sign of A - B

    always_comb begin
        finalResult = sliceResult;
        if (ctrl.sel == SEL_SLT) begin
            finalResult[0] = sltValue;
        end
    end

    assign bus.result   = finalResult;
    assign bus.carryout = carry[Width];
    assign bus.overflow = isArith & rawOverflow;  // Logic ops never overflow

    assign bus.zero     = ~|finalResult;

    // Overflow needs an adder command and operand signs that allow it
    overflowOnlyArith: assert property (
        @(posedge bus.clk)
        bus.overflow |-> ((bus.command == CMD_ADD
                           && bus.operandA[Width-1] == bus.operandB[Width-1])
                          || (bus.command inside {CMD_SUB, CMD_SLT}
                              && bus.operandA[Width-1] != bus.operandB[Width-1]))
    ) else $error("overflow raised on command %0d", bus.command);

endmodule

`default_nettype wire

// ==== hw/regFile.sv ====
// Register file with two combinational read ports and one synchronous write port

`timescale 1ns/1ps
`default_nettype none

`include "alu_cfg.svh"

module regFile (
    input  logic                      clk,
    input  logic                      reset,
    input  logic [`REG_ADDR_BITS-1:0] rdAddrA,
    input  logic [`REG_ADDR_BITS-1:0] rdAddrB,
    output logic [`ALU_WIDTH-1:0]     rdDataA,
    output logic [`ALU_WIDTH-1:0]     rdDataB,
    input  logic                      wrEn,
    input  logic [`REG_ADDR_BITS-1:0] wrAddr,
    input  logic [`ALU_WIDTH-1:0]     wrData
);

    logic [`ALU_WIDTH-1:0] regs [`REG_COUNT];

    always_ff @(posedge clk) begin
        if (reset) begin
            for (int i = 0; i < `REG_COUNT; i++) begin
                regs[i] <= `ALU_ZERO;
            end
        end else if (wrEn) begin
            regs[wrAddr] <= wrData;  // Visible to reads from the next cycle
        end
    end

    // Reads see the contents before the current edge
    assign rdDataA = regs[rdAddrA];
    assign rdDataB = regs[rdAddrB];

endmodule

`default_nettype wire

// ==== hw/aluCore.sv ====
// Execute unit top level that loads registers, runs ALU ops on them and registers the results

`timescale 1ns/1ps
`default_nettype none

`include "alu_cfg.svh"

module aluCore (
    input  logic                      clk,
    input  logic                      reset,
    input  logic                      loadValid,
    input  logic [`REG_ADDR_BITS-1:0] loadAddr,
    input  logic [`ALU_WIDTH-1:0]     loadData,
    input  logic                      execValid,
    input  aluPkg::aluCmd_t           command,
    input  logic [`REG_ADDR_BITS-1:0] srcA,
    input  logic [`REG_ADDR_BITS-1:0] srcB,
    input  logic [`REG_ADDR_BITS-1:0] dest,
    output logic                      resultValid,
    output logic [`ALU_WIDTH-1:0]     result,
    output logic                      carryout,
    output logic                      zero,
    output logic                      overflow
);

    logic [`ALU_WIDTH-1:0]     rdDataA;
    logic [`ALU_WIDTH-1:0]     rdDataB;
    logic                      wrEn;
    logic [`REG_ADDR_BITS-1:0] wrAddr;
    logic [`ALU_WIDTH-1:0]     wrData;

    aluIf aluBus (.clk(clk));

    // Execute owns the write port when active, otherwise the load path
    assign wrEn   = loadValid | execValid;
    assign wrAddr = execValid ? dest : loadAddr;
    assign wrData = execValid ? aluBus.result : loadData;

    regFile i_regFile (
        .clk    (clk),
        .reset  (reset),
        .rdAddrA(srcA),
        .rdAddrB(srcB),
        .rdDataA(rdDataA),
        .rdDataB(rdDataB),
        .wrEn   (wrEn),
        .wrAddr (wrAddr),
        .wrData (wrData)
    );

    assign aluBus.operandA = rdDataA;
    assign aluBus.operandB = rdDataB;
    assign aluBus.command  = command;

    aluBits i_aluBits (
        .bus(aluBus.alu)
    );

    always_ff @(posedge clk) begin
        if (reset) begin
            resultValid <= 1'b0;
            result      <= `ALU_ZERO;
            carryout    <= 1'b0;
            zero        <= 1'b0;
            overflow    <= 1'b0;
        end else begin
            resultValid <= execValid;  // One-cycle pulse per execute
            if (execValid) begin
                result   <= aluBus.result;
                carryout <= aluBus.carryout;
                zero     <= aluBus.zero;
                overflow <= aluBus.overflow;
            end
        end
    end

    // Both strobes would fight over the single write port
    noLoadDuringExec: assert property (
        @(posedge clk) disable iff (reset)
        !(loadValid && execValid)
    ) else $error("loadValid and execValid high together");

endmodule

`default_nettype wire

// ==== tb/clockGen.sv ====
// Testbench clock and synchronous reset source, instantiated once by the top testbench

`timescale 1ns/1ps
`default_nettype none

module clockGen #(
    parameter int PeriodNs    = 4,
    parameter int ResetCycles = 2
) (
    output logic clk,
    output logic reset
);

    initial begin
        clk = 1'b0;
        forever #(PeriodNs / 2) clk = ~clk;
    end

    // Reset drops just after an edge, like any other input
    initial begin
        reset = 1'b1;
        repeat (ResetCycles) @(posedge clk);
        #1 reset = 1'b0;
    end

endmodule

`default_nettype wire

// ==== tb/aluCoreTb.sv ====
// Top testbench for the execute unit: drives loads and executes, checks outputs with assertions

`timescale 1ns/1ps
`default_nettype none

`include "alu_cfg.svh"

module aluCoreTb;
    import aluPkg::*;

    localparam int Width      = `ALU_WIDTH;
    localparam int NumRandom  = 8;
    localparam int Issued     = 22 * NumRandom + 43;  // Reset plus every test's cycles
    localparam int CycleLimit = 2 * Issued + 50;

    logic                      clk;
    logic                      reset;
    logic                      loadValid;
    logic [`REG_ADDR_BITS-1:0] loadAddr;
    logic [Width-1:0]          loadData;
    logic                      execValid;
    aluCmd_t                   command;
    logic [`REG_ADDR_BITS-1:0] srcA;
    logic [`REG_ADDR_BITS-1:0] srcB;
    logic [`REG_ADDR_BITS-1:0] dest;
    logic                      resultValid;
    logic [Width-1:0]          result;
    logic                      carryout;
    logic                      zero;
    logic                      overflow;

    logic [Width-1:0] model [`REG_COUNT];  // Expected register contents
    logic [Width-1:0] expResult;
    logic             expCarry;
    logic             expZero;
    logic             expOverflow;
    logic [Width-1:0] chkResult   = '0;    // Expected values latched at the execute edge
    logic             chkCarry    = 1'b0;
    logic             chkZero     = 1'b0;
    logic             chkOverflow = 1'b0;
    string            chkName     = "none";
    logic             execSeen    = 1'b0;
    logic [31:0]      rngState    = 32'heda7;
    string            testName    = "none";
    int               failCount   = 0;
    int               execCount   = 0;
    int               testCount   = 0;
    int               failAtStart;
    int               execAtStart;
    int               cycleCount  = 0;
    logic [Width-1:0] wordA;
    logic [Width-1:0] wordB;

    clockGen #(.PeriodNs(4), .ResetCycles(2)) i_clockGen (.clk(clk), .reset(reset));

    aluCore i_aluCore (
        .clk        (clk),
        .reset      (reset),
        .loadValid  (loadValid),
        .loadAddr   (loadAddr),
        .loadData   (loadData),
        .execValid  (execValid),
        .command    (command),
        .srcA       (srcA),
        .srcB       (srcB),
        .dest       (dest),
        .resultValid(resultValid),
        .result     (result),
        .carryout   (carryout),
        .zero       (zero),
        .overflow   (overflow)
    );

    function automatic logic [31:0] xorshift(input logic [31:0] s);
        logic [31:0] x;
        x = s;
        x = x ^ (x << 13);
        x = x ^ (x >> 17);
        x = x ^ (x << 5);
        return x;
    endfunction

    function automatic logic [31:0] drawRandom();
        rngState = xorshift(rngState);
        return rngState;
    endfunction

    // Reference model straight from the command rules
    function automatic void predict(input aluCmd_t cmd, input logic [Width-1:0] a,
                                    input logic [Width-1:0] b);
        logic [Width:0] addWide;
        logic [Width:0] subWide;
        logic           addOvf;
        logic           subOvf;
        addWide = {1'b0, a} + {1'b0, b};
        subWide = {1'b0, a} + {1'b0, ~b} + {{Width{1'b0}}, 1'b1};
        addOvf  = (a[Width-1] == b[Width-1]) && (addWide[Width-1] != a[Width-1]);
        subOvf  = (a[Width-1] != b[Width-1]) && (subWide[Width-1] != a[Width-1]);
        expCarry    = addWide[Width];  // Logic commands still run A + B in the adder
        expOverflow = 1'b0;
        case (cmd)
            CMD_ADD: begin
                expResult   = addWide[Width-1:0];
                expOverflow = addOvf;
            end
            CMD_SUB: begin
                expResult   = subWide[Width-1:0];
                expCarry    = subWide[Width];
                expOverflow = subOvf;
            end
            CMD_SLT: begin
                expResult   = {{(Width-1){1'b0}}, ($signed(a) < $signed(b))};
                expCarry    = subWide[Width];
                expOverflow = subOvf;
            end
            CMD_XOR:  expResult = a ^ b;
            CMD_AND:  expResult = a & b;
            CMD_NAND: expResult = ~(a & b);
            CMD_NOR:  expResult = ~(a | b);
            default:  expResult = a | b;
        endcase
        expZero = (expResult == '0);
    endfunction

    task automatic idle(input int n);
        repeat (n) begin
            @(posedge clk);
            #1;
        end
    endtask

    task automatic loadReg(input logic [`REG_ADDR_BITS-1:0] addr, input logic [Width-1:0] data);
        loadValid = 1'b1;
        loadAddr  = addr;
        loadData  = data;
        @(posedge clk);
        #1;
        model[addr] = data;
        loadValid   = 1'b0;
    endtask

    // One execute, leaving the strobe low afterwards so the next call may follow at once
    task automatic execOp(input aluCmd_t cmd, input logic [`REG_ADDR_BITS-1:0] a,
                          input logic [`REG_ADDR_BITS-1:0] b, input logic [`REG_ADDR_BITS-1:0] d);
        predict(cmd, model[a], model[b]);
        execValid = 1'b1;
        command   = cmd;
        srcA      = a;
        srcB      = b;
        dest      = d;
        @(posedge clk);
        #1;
        model[d]  = expResult;  // Write-back lands at this edge
        execValid = 1'b0;
        execCount = execCount + 1;
    endtask

    task automatic execCheck(input aluCmd_t cmd, input logic [`REG_ADDR_BITS-1:0] a,
                             input logic [`REG_ADDR_BITS-1:0] b, input logic [`REG_ADDR_BITS-1:0] d);
        execOp(cmd, a, b, d);
        idle(1);
    endtask

    task automatic startTest(input string name);
        testName    = name;
        failAtStart = failCount;
        execAtStart = execCount;
    endtask

    task automatic finishTest();
        testCount = testCount + 1;
        $display("test %-12s %0d executes, %0d failures", testName,
                 execCount - execAtStart, failCount - failAtStart);
    endtask

    always @(posedge clk) begin
        if (reset) begin
            execSeen <= 1'b0;
        end else if (execValid) begin
            execSeen    <= 1'b1;
            chkResult   <= expResult;
            chkCarry    <= expCarry;
            chkZero     <= expZero;
            chkOverflow <= expOverflow;
            chkName     <= testName;
        end
    end

    resultMatch: assert property (@(posedge clk) disable iff (reset)
        execValid |=> result == chkResult)
    else begin
        failCount = failCount + 1;
        $display("[FAIL] %s result: expected %h, actual %h",
                 chkName, $sampled(chkResult), $sampled(result));
    end

    carryMatch: assert property (@(posedge clk) disable iff (reset)
        execValid |=> carryout == chkCarry)
    else begin
        failCount = failCount + 1;
        $display("[FAIL] %s carryout: expected %b, actual %b",
                 chkName, $sampled(chkCarry), $sampled(carryout));
    end

    zeroMatch: assert property (@(posedge clk) disable iff (reset)
        execValid |=> zero == chkZero)
    else begin
        failCount = failCount + 1;
        $display("[FAIL] %s zero: expected %b, actual %b",
                 chkName, $sampled(chkZero), $sampled(zero));
    end

    overflowMatch: assert property (@(posedge clk) disable iff (reset)
        execValid |=> overflow == chkOverflow)
    else begin
        failCount = failCount + 1;
        $display("[FAIL] %s overflow: expected %b, actual %b",
                 chkName, $sampled(chkOverflow), $sampled(overflow));
    end

    // One pulse per execute, never held over
    pulseMatch: assert property (@(posedge clk) disable iff (reset)
        resultValid == $past(execValid))
    else begin
        failCount = failCount + 1;
        $display("resultValid pulse does not follow execValid in test %s", testName);
    end

    idleBeforeExec: assert property (@(posedge clk) disable iff (reset)
        !execSeen |-> !resultValid)
    else begin
        failCount = failCount + 1;
        $display("resultValid went high before any execute was issued");
    end

    always @(posedge clk) begin
        cycleCount <= cycleCount + 1;
        if (cycleCount >= CycleLimit) begin
            $display("Run stopped after %0d cycles without finishing", CycleLimit);
            $display("TB FAILED");
            $finish;
        end
    end

    initial begin
        loadValid = 1'b0;
        loadAddr  = '0;
        loadData  = '0;
        execValid = 1'b0;
        command   = CMD_ADD;
        srcA      = '0;
        srcB      = '0;
        dest      = '0;
        for (int i = 0; i < `REG_COUNT; i++) begin
            model[i] = '0;
        end
        wait (reset == 1'b0);

        startTest("resetIdle");
        idle(4);
        execCheck(CMD_ADD, 3'd5, 3'd6, 3'd7);  // Never loaded, reads as zero
        finishTest();

        startTest("addSub");
        for (int i = 0; i < NumRandom; i++) begin
            loadReg(3'd1, drawRandom());
            loadReg(3'd2, drawRandom());
            execCheck(CMD_ADD, 3'd1, 3'd2, 3'd3);
            execCheck(CMD_SUB, 3'd1, 3'd2, 3'd4);
        end
        loadReg(3'd1, 32'h7fffffff);
        loadReg(3'd2, 32'h00000001);
        execCheck(CMD_ADD, 3'd1, 3'd2, 3'd3);
        loadReg(3'd1, 32'h80000000);
        loadReg(3'd2, 32'h00000001);
        execCheck(CMD_SUB, 3'd1, 3'd2, 3'd3);
        finishTest();

        startTest("logicOps");
        for (int i = 0; i < NumRandom; i++) begin
            loadReg(3'd1, drawRandom());
            loadReg(3'd2, drawRandom());
            execCheck(CMD_XOR, 3'd1, 3'd2, 3'd3);
            execCheck(CMD_AND, 3'd1, 3'd2, 3'd4);
            execCheck(CMD_NAND, 3'd1, 3'd2, 3'd5);
            execCheck(CMD_NOR, 3'd1, 3'd2, 3'd6);
            execCheck(CMD_OR, 3'd1, 3'd2, 3'd7);
        end
        finishTest();

        startTest("setLessThan");
        for (int i = 0; i < NumRandom; i++) begin
            loadReg(3'd1, drawRandom());
            loadReg(3'd2, drawRandom());
            execCheck(CMD_SLT, 3'd1, 3'd2, 3'd3);
        end
        for (int i = 0; i < 3; i++) begin
            // Pairs whose subtraction overflows
            wordA = (i == 0) ? 32'h80000000 : (i == 1) ? 32'h00000001 : 32'h7fffffff;
            wordB = (i == 0) ? 32'h00000001 : (i == 1) ? 32'h80000000 : 32'hffffffff;
            loadReg(3'd1, wordA);
            loadReg(3'd2, wordB);
            execCheck(CMD_SLT, 3'd1, 3'd2, 3'd3);
        end
        finishTest();

        startTest("zeroFlag");
        wordA = drawRandom();
        loadReg(3'd1, wordA);
        execCheck(CMD_SUB, 3'd1, 3'd1, 3'd3);
        loadReg(3'd2, wordA ^ 32'h00000001);
        execCheck(CMD_SUB, 3'd1, 3'd2, 3'd4);
        finishTest();

        startTest("backToBack");
        loadReg(3'd1, drawRandom());
        loadReg(3'd2, drawRandom());
        execOp(CMD_ADD, 3'd1, 3'd2, 3'd3);
        execOp(CMD_SUB, 3'd3, 3'd1, 3'd4);
        execOp(CMD_XOR, 3'd4, 3'd3, 3'd5);
        execOp(CMD_ADD, 3'd5, 3'd5, 3'd6);
        execOp(CMD_OR, 3'd6, 3'd2, 3'd7);
        execOp(CMD_SLT, 3'd7, 3'd1, 3'd1);
        idle(1);
        finishTest();

        $display("Summary: %0d tests, %0d executes, %0d failures",
                 testCount, execCount, failCount);
        if (failCount == 0) begin
            $display("TB PASSED");
        end else begin
            $display("TB FAILED");
        end
        $finish;
    end

endmodule

`default_nettype wire

// ==== bitSliceAlu.f ====
+incdir+hw
hw/aluPkg.sv
hw/aluIf.sv
hw/aluControl.sv
hw/aluSlice.sv
hw/aluBits.sv
hw/regFile.sv
hw/aluCore.sv
tb/clockGen.sv
tb/aluCoreTb.sv

// ==== Makefile ====
# Verilator build and run for the bit-sliced ALU execute unit

SIM      ?= verilator
FLAGS    ?= --binary --timing --assert --timescale 1ns/1ps -j 0
TOP      ?= aluCoreTb
FILELIST ?= bitSliceAlu.f
BUILDDIR ?= obj_dir
LOG      ?= sim.log

.PHONY: help test clean

help:
	@echo "Targets:"
	@echo "  test   build with Verilator, run the testbench, fail on a failing run"
	@echo "  clean  remove the build directory and the log"
	@echo "  help   show this list"

$(BUILDDIR)/V$(TOP): $(FILELIST)
	$(SIM) $(FLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(BUILDDIR)

test: $(BUILDDIR)/V$(TOP)
	@./$(BUILDDIR)/V$(TOP) > $(LOG) 2>&1; status=$$?; \
	cat $(LOG); \
	if [ $$status -ne 0 ] || grep -q "TB FAILED" $(LOG); then \
		echo "Simulation reported a failure, see $(LOG)"; \
		exit 1; \
	fi

clean:
	rm -rf $(BUILDDIR) $(LOG)
